//--- Bender.yml
package:
  name: trellis_decoder

sources:
  - include_dirs:
      - design
    files:
      - design/trellisPkg.sv
      - design/branchMetric.sv
      - design/acsUnit.sv
      - design/survivorExchange.sv
      - design/trellisDecoder.sv
  - target: test
    include_dirs:
      - design
      - verif
    files:
      - verif/trellisDecoderTb.sv

//--- design/acsUnit.sv
// add-compare-select for the 4-state 7/5 code with max normalization
// one update per branchMetrics valid, result one clock later
`include "trellisParams.svh"

module acsUnit (
  input  logic                     clk,
  input  logic                     reset,
  input  trellisPkg::branchMetrics metrics,
  output trellisPkg::acsResult     result
);
  import trellisPkg::*;

  localparam int CandWidth = `METRIC_WIDTH + 1;
  localparam int DiffWidth = `METRIC_WIDTH + 2;
  // most negative path metric is the saturation floor
  localparam logic signed [DiffWidth-1:0] MinMetric = -(2 ** (`METRIC_WIDTH - 1));

  pathMetric                    pathMetrics [4];
  pathMetric                    normMetric [4];
  logic signed [CandWidth-1:0]  candLo [4];
  logic signed [CandWidth-1:0]  candHi [4];
  logic signed [CandWidth-1:0]  newMetric [4];
  logic signed [CandWidth-1:0]  bestMetric;
  logic signed [DiffWidth-1:0]  diff [4];
  logic [3:0]                   pick;
  stateIndex                    bestIdx;

  // encoder outputs for input bit leaving state pred
  // g0 = 111, g1 = 101
  function automatic logic [1:0] codedPair(input stateIndex pred, input logic bitIn);
    codedPair = {bitIn ^ pred[1] ^ pred[0], bitIn ^ pred[0]};
  endfunction

  // --------------------
  // add and compare
  // --------------------
  // state s = {u, x} comes from {x, 0} or {x, 1}
  always_comb begin
    for (int s = 0; s < 4; s++) begin
      candLo[s] = pathMetrics[2 * (s % 2)] +
                  $signed(metrics.metric[codedPair(2'(2 * (s % 2)), 1'(s / 2))]);
      candHi[s] = pathMetrics[2 * (s % 2) + 1] +
                  $signed(metrics.metric[codedPair(2'(2 * (s % 2) + 1), 1'(s / 2))]);
      // strict compare so a tie keeps the lower predecessor
      pick[s] = candHi[s] > candLo[s];
      newMetric[s] = pick[s] ? candHi[s] : candLo[s];
    end
  end

  // best state search with the lowest index winning a tie
  always_comb begin
    bestIdx = 2'd0;
    bestMetric = newMetric[0];
    for (int s = 1; s < 4; s++) begin
      if (newMetric[s] > bestMetric) begin
        bestIdx = 2'(s);
        bestMetric = newMetric[s];
      end
    end
  end

  // --------------------
  // normalization
  // --------------------
  // subtract the max, clip at the floor
  always_comb begin
    for (int s = 0; s < 4; s++) begin
      diff[s] = newMetric[s] - bestMetric;
      normMetric[s] = (diff[s] < MinMetric) ? pathMetric'(MinMetric) : pathMetric'(diff[s]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < 4; s++) begin
        pathMetrics[s] <= '0;
      end
      result <= '0;
    end else begin
      result.valid <= metrics.valid;
      if (metrics.valid) begin
        pathMetrics <= normMetric;
        result.select <= pick;
        result.bestState <= bestIdx;
      end
    end
  end

  // best state metric is zero after each update and no state is above it
  assert property (@(posedge clk) disable iff (reset)
    result.valid |-> (pathMetrics[result.bestState] == 0) &&
      (pathMetrics[0] <= 0) && (pathMetrics[1] <= 0) &&
      (pathMetrics[2] <= 0) && (pathMetrics[3] <= 0));

  // branch metrics arrive as one-clock pulses
  assert property (@(posedge clk) disable iff (reset)
    metrics.valid |=> !metrics.valid);

endmodule

//--- design/branchMetric.sv
// collects the I and Q soft samples of one symbol
// and forms the four correlation branch metrics for the ACS
`include "trellisParams.svh"

module branchMetric (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     symEn,
  input  logic                     sym2xEn,
  input  trellisPkg::softSample    sampleIn,
  output trellisPkg::branchMetrics metrics
);
  import trellisPkg::*;

  // room for -I - Q at full negative scale
  localparam int SumWidth = `SOFT_WIDTH + 2;
  localparam logic signed [SumWidth-1:0] MaxBranch = (2 ** `SOFT_WIDTH) - 1;

  softSample                   iHeld;
  logic                        haveI;
  logic signed [SumWidth-1:0]  iWide;
  logic signed [SumWidth-1:0]  qWide;
  logic signed [SumWidth-1:0]  sum [4];
  branchWord [3:0]             nextMetric;
  branchWord [3:0]             metricReg;
  logic                        metricValid;

  // sign extend before negating
  assign iWide = iHeld;
  assign qWide = sampleIn;

  // --------------------
  // correlation sums
  // --------------------
  // negate I when c0 is 1, Q when c1 is 1
  // only +64 can overflow, clip it to the top code
  always_comb begin
    for (int p = 0; p < 4; p++) begin
      sum[p] = ((p >= 2) ? -iWide : iWide) + ((p % 2 == 1) ? -qWide : qWide);
      nextMetric[p] = (sum[p] > MaxBranch) ? branchWord'(MaxBranch) : branchWord'(sum[p]);
    end
  end

  // I on symEn, Q on the next lone sym2xEn
  always_ff @(posedge clk) begin
    if (reset) begin
      haveI <= 1'b0;
      metricValid <= 1'b0;
    end else begin
      metricValid <= 1'b0;
      if (sym2xEn && symEn) begin
        haveI <= 1'b1;
      end else if (sym2xEn && haveI) begin
        haveI <= 1'b0;
        metricValid <= 1'b1;
      end
    end
  end

  // sample and metric payload
  always_ff @(posedge clk) begin
    if (sym2xEn && symEn) begin
      iHeld <= sampleIn;
    end
    if (sym2xEn && !symEn && haveI) begin
      metricReg <= nextMetric;
    end
  end

  assign metrics = '{metric: metricReg, valid: metricValid};

endmodule

//--- design/survivorExchange.sv
// register-exchange survivor memory
// emits the bit leaving the best state's survivor, DEPTH symbols late
`include "trellisParams.svh"

module survivorExchange #(
  parameter int DEPTH = `TB_DEPTH
) (
  input  logic                 clk,
  input  logic                 reset,
  input  trellisPkg::acsResult result,
  output logic                 decision,
  output logic                 decisionValid,
  output logic [1:0]           bestState
);
  import trellisPkg::*;

  localparam int CountWidth = $clog2(DEPTH + 1);

  // oldest bit in the msb
  logic [DEPTH-1:0]      survivors [4];
  logic [DEPTH-1:0]      nextSurvivors [4];
  stateIndex             predIdx [4];
  // bit shifted out of each new survivor
  logic [3:0]            oldestBits;
  logic [CountWidth-1:0] symCount;

  // --------------------
  // exchange
  // --------------------
  // copy the winning predecessor, append the state's newest bit
  always_comb begin
    for (int s = 0; s < 4; s++) begin
      predIdx[s] = {1'(s % 2), result.select[s]};
      nextSurvivors[s] = {survivors[predIdx[s]][DEPTH-2:0], 1'(s / 2)};
      oldestBits[s] = survivors[predIdx[s]][DEPTH-1];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < 4; s++) begin
        survivors[s] <= '0;
      end
      symCount <= '0;
      decisionValid <= 1'b0;
    end else begin
      // decisions only once every survivor holds real history
      decisionValid <= result.valid && (symCount == CountWidth'(DEPTH));
      if (result.valid) begin
        survivors <= nextSurvivors;
        // saturates at DEPTH
        if (symCount != CountWidth'(DEPTH)) begin
          symCount <= symCount + 1'b1;
        end
      end
    end
  end

  // --------------------
  // outputs
  // --------------------
  always_ff @(posedge clk) begin
    if (result.valid) begin
      decision <= oldestBits[result.bestState];
      bestState <= result.bestState;
    end
  end

  // quiet for the first DEPTH symbols after reset
  assert property (@(posedge clk) disable iff (reset)
    $fell(reset) |-> !decisionValid throughout (result.valid [-> DEPTH] ##1 1'b1));

endmodule

//--- design/trellisDecoder.sv
// soft-decision Viterbi detector for the 4-state 7/5 code
// Q strobe to decisionValid is 3 clocks
module trellisDecoder (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  symEn,
  input  logic                  sym2xEn,
  input  trellisPkg::softSample sampleIn,
  output logic                  decision,
  output logic                  decisionValid,
  output logic [1:0]            bestState
);
  import trellisPkg::*;

  branchMetrics branchBus;
  acsResult     acsBus;

  // I/Q pair to branch metrics
  branchMetric u_branchMetric (
    .clk      (clk),
    .reset    (reset),
    .symEn    (symEn),
    .sym2xEn  (sym2xEn),
    .sampleIn (sampleIn),
    .metrics  (branchBus)
  );

  // path metrics and survivor selects
  acsUnit u_acsUnit (
    .clk     (clk),
    .reset   (reset),
    .metrics (branchBus),
    .result  (acsBus)
  );

  // survivors and delayed decision
  survivorExchange u_survivorExchange (
    .clk           (clk),
    .reset         (reset),
    .result        (acsBus),
    .decision      (decision),
    .decisionValid (decisionValid),
    .bestState     (bestState)
  );

endmodule

//--- design/trellisParams.svh
// widths and depths shared by the trellis detector RTL and its testbench
// include wherever a width or depth is needed
`ifndef TRELLIS_PARAMS_SVH
`define TRELLIS_PARAMS_SVH

// signed soft sample, positive means coded bit 0
`define SOFT_WIDTH 6

// signed path metric, best state normalized to zero
`define METRIC_WIDTH 10

// survivor length in symbols, also the decision delay
`define TB_DEPTH 16

`endif

//--- design/trellisPkg.sv
// types passed between the trellis detector stages
// the testbench model uses the same types
`include "trellisParams.svh"

package trellisPkg;

  // --------------------
  // sample and metric words
  // --------------------

  // one soft I or Q value from the demodulator
  typedef logic signed [`SOFT_WIDTH-1:0] softSample;

  // correlation of one I/Q pair against one coded pair
  typedef logic signed [`SOFT_WIDTH:0] branchWord;

  // accumulated path metric per state
  typedef logic signed [`METRIC_WIDTH-1:0] pathMetric;

  // state = last two input bits, newest in the msb
  typedef logic [1:0] stateIndex;

  // --------------------
  // stage to stage structs
  // --------------------

  // indexed by coded pair {c0, c1}
  typedef struct packed {
    branchWord [3:0] metric;
    logic            valid;
  } branchMetrics;

  // select bit set when the odd predecessor won
  typedef struct packed {
    logic [3:0] select;
    stateIndex  bestState;
    logic       valid;
  } acsResult;

endpackage

//--- sim.f
+incdir+design
+incdir+verif
design/trellisPkg.sv
design/branchMetric.sv
design/acsUnit.sv
design/survivorExchange.sv
design/trellisDecoder.sv
verif/trellisDecoderTb.sv

//--- verif/trellisModel.svh
// reference model for the trellis detector testbench
// included in the testbench module body, holds the encoder, noise and Viterbi model
`ifndef TRELLIS_MODEL_SVH
`define TRELLIS_MODEL_SVH

localparam int SampleMax = (1 << (`SOFT_WIDTH - 1)) - 1;
localparam int SampleMin = -(1 << (`SOFT_WIDTH - 1));
localparam int ScoreMax = (1 << `SOFT_WIDTH) - 1;
localparam int MetricFloor = -(1 << (`METRIC_WIDTH - 1));
localparam int NoiseSpan = 12;

logic [31:0]          rngState = 32'd16;
// last two input bits, newest in the msb
logic [1:0]           encState = 2'b00;
int                   modelMetric [4];
logic [`TB_DEPTH-1:0] modelPath [4];
int                   modelSymbols;

// --------------------
// random numbers
// --------------------
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic logic [31:0] randomNext();
  rngState = xorshift32(rngState);
  return rngState;
endfunction

// --------------------
// encoder and channel
// --------------------
// returns {c0, c1}, g0 = 7, g1 = 5
function automatic logic [1:0] encodeBit(input logic u);
  logic [1:0] pair;
  pair = {u ^ encState[1] ^ encState[0], u ^ encState[0]};
  encState = {u, encState[1]};
  return pair;
endfunction

// coded 0 maps to +amp, noise bounded, clipped to the sample range
function automatic softSample softValue(input logic c, input int amp, input logic noisy);
  logic [31:0] r;
  int value;
  value = c ? -amp : amp;
  if (noisy) begin
    r = randomNext();
    value = value + int'((r >> 3) % (2 * NoiseSpan + 1)) - NoiseSpan;
  end
  if (value > SampleMax)
    value = SampleMax;
  if (value < SampleMin)
    value = SampleMin;
  return softSample'(value);
endfunction

// --------------------
// Viterbi model
// --------------------
function automatic void modelClear();
  for (int s = 0; s < 4; s++) begin
    modelMetric[s] = 0;
    modelPath[s] = '0;
  end
  modelSymbols = 0;
endfunction

// correlation with one coded pair, top code only
function automatic int pairScore(input int iVal, input int qVal, input int c0, input int c1);
  int score;
  score = ((c0 != 0) ? -iVal : iVal) + ((c1 != 0) ? -qVal : qVal);
  if (score > ScoreMax)
    score = ScoreMax;
  return score;
endfunction

// one trellis step, returns the bit leaving the best survivor
function automatic void modelStep(input int iVal, input int qVal,
                                  output logic bitOut, output logic [1:0] stateOut);
  int                   cand [2];
  int                   grown [4];
  logic [`TB_DEPTH-1:0] grownPath [4];
  logic [3:0]           leaving;
  int                   pred;
  int                   winner;
  int                   bestIdx;
  int                   diff;
  for (int s = 0; s < 4; s++) begin
    // predecessors {x, 0} and {x, 1} with x the old newest bit
    for (int k = 0; k < 2; k++) begin
      pred = ((s & 1) << 1) | k;
      cand[k] = modelMetric[pred] + pairScore(iVal, qVal,
        (s >> 1) ^ (pred >> 1) ^ (pred & 1), (s >> 1) ^ (pred & 1));
    end
    winner = (cand[1] > cand[0]) ? 1 : 0;
    pred = ((s & 1) << 1) | winner;
    grown[s] = cand[winner];
    grownPath[s] = {modelPath[pred][`TB_DEPTH-2:0], 1'(s >> 1)};
    leaving[s] = modelPath[pred][`TB_DEPTH-1];
  end
  bestIdx = 0;
  for (int s = 1; s < 4; s++) begin
    if (grown[s] > grown[bestIdx])
      bestIdx = s;
  end
  for (int s = 0; s < 4; s++) begin
    diff = grown[s] - grown[bestIdx];
    modelMetric[s] = (diff < MetricFloor) ? MetricFloor : diff;
    modelPath[s] = grownPath[s];
  end
  bitOut = leaving[bestIdx];
  stateOut = 2'(bestIdx);
  modelSymbols++;
endfunction

`endif

//--- verif/trellisDecoderTb.sv
// testbench for the trellis detector, random symbols checked against a model
// five tests run back to back, each from a fresh reset
`include "trellisParams.svh"

module trellisDecoderTb;
  import trellisPkg::*;

  localparam int ResetCycles = 8;
  localparam int Latency = 3;
  localparam int LongIdleMin = 20;
  localparam int LongIdleMax = 40;
  localparam int ModeModel = 0;
  localparam int ModeHistory = 1;
  localparam int ModeZero = 2;
  // all tests, the cut symbol of test 5 counted once
  localparam int TotalSymbols = 60 + 80 + 40 + 50 + 30 + 1 + 40;
  // two samples per symbol at the longest spacing, plus resets and drain
  localparam int CycleLimit = TotalSymbols * 2 * (LongIdleMax + 2) +
                              6 * (ResetCycles + 8) + 200;

  logic      clk;
  logic      reset;
  logic      symEn;
  logic      sym2xEn;
  softSample sampleIn;
  logic      decision;
  logic      decisionValid;
  logic [1:0] bestState;

  // scoreboard
  int         cycleCount = 0;
  int         errorCount = 0;
  int         checkCount = 0;
  int         testErrStart = 0;
  int         decisionsSinceReset = 0;
  int         checkMode = ModeModel;
  int         heldI;
  logic       haveI;
  logic       expBits [$];
  logic [1:0] expStates [$];
  int         qCycles [$];
  logic       truthBits [$];

  `include "trellisModel.svh"

  trellisDecoder u_trellisDecoder (
    .clk           (clk),
    .reset         (reset),
    .symEn         (symEn),
    .sym2xEn       (sym2xEn),
    .sampleIn      (sampleIn),
    .decision      (decision),
    .decisionValid (decisionValid),
    .bestState     (bestState)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------
  // stimulus
  // --------------------
  // strobe for one cycle, then at least one idle cycle
  task automatic sendSample(input logic isI, input softSample value, input int idle);
    @(posedge clk);
    symEn <= isI;
    sym2xEn <= 1'b1;
    sampleIn <= value;
    @(posedge clk);
    symEn <= 1'b0;
    sym2xEn <= 1'b0;
    repeat (idle) @(posedge clk);
  endtask

  // extra idle cycles, now and then a long gap
  function automatic int pickIdle(input logic longGaps);
    logic [31:0] r;
    r = randomNext();
    if (longGaps && r[6:4] == 3'd0) begin
      return LongIdleMin + int'((r >> 8) % (LongIdleMax - LongIdleMin + 1));
    end
    return int'((r >> 8) % 3);
  endfunction

  // I carries c0, Q carries c1
  task automatic sendSymbol(input logic u, input int amp, input logic noisy,
                            input logic longGaps);
    logic [1:0] pair;
    pair = encodeBit(u);
    truthBits.push_back(u);
    sendSample(1'b1, softValue(pair[1], amp, noisy), pickIdle(longGaps));
    sendSample(1'b0, softValue(pair[0], amp, noisy), pickIdle(longGaps));
  endtask

  task automatic runStream(input int count, input int amp, input logic noisy,
                           input logic zeroBits, input logic longGaps);
    logic [31:0] r;
    for (int n = 0; n < count; n++) begin
      r = randomNext();
      sendSymbol(zeroBits ? 1'b0 : r[9], amp, noisy, longGaps);
    end
  endtask

  task automatic applyReset();
    @(posedge clk);
    reset <= 1'b1;
    symEn <= 1'b0;
    sym2xEn <= 1'b0;
    repeat (ResetCycles) @(posedge clk);
    reset <= 1'b0;
    truthBits.delete();
    encState = 2'b00;
  endtask

  task automatic startTest(input int mode);
    applyReset();
    checkMode = mode;
    testErrStart = errorCount;
  endtask

  // wait for the pipeline to drain, then one line per test
  task automatic finishTest(input int num, input string name, input int wantDecisions);
    @(negedge clk);
    while (qCycles.size() != 0) @(negedge clk);
    if (decisionsSinceReset != wantDecisions) begin
      $display("test %0d gave %0d decisions after its last reset instead of %0d",
               num, decisionsSinceReset, wantDecisions);
      errorCount++;
    end
    $display("test %0d, %s: %0d decisions, %0d errors", num, name,
             decisionsSinceReset, errorCount - testErrStart);
  endtask

  // --------------------
  // monitor and checks
  // --------------------
  task automatic checkOutputs();
    logic       wantBit;
    logic [1:0] wantState;
    logic       sentBit;
    int         sentAt;
    if (decisionValid) begin
      decisionsSinceReset++;
      if (qCycles.size() == 0) begin
        $display("decisionValid came before %0d symbols were processed", `TB_DEPTH);
        errorCount++;
      end else begin
        sentAt = qCycles.pop_front();
        wantBit = expBits.pop_front();
        wantState = expStates.pop_front();
        checkCount++;
        if (cycleCount - sentAt != Latency) begin
          $display("decisionValid came %0d clocks after its Q strobe instead of %0d",
                   cycleCount - sentAt, Latency);
          errorCount++;
        end
        if (decision !== wantBit) begin
          $display("Error: decision = %h, expected %h", decision, wantBit);
          errorCount++;
        end
        if (bestState !== wantState) begin
          $display("Error: bestState = %h, expected %h", bestState, wantState);
          errorCount++;
        end
        // noiseless runs, the bit sent TB_DEPTH symbols earlier
        if (checkMode == ModeHistory) begin
          sentBit = truthBits.pop_front();
          if (decision !== sentBit) begin
            $display("Error: decision = %h, expected sent bit %h", decision, sentBit);
            errorCount++;
          end
        end
        if (checkMode == ModeZero) begin
          if (decision !== 1'b0 || bestState !== 2'd0) begin
            $display("Error: decision = %h, bestState = %h, expected 0 and 0",
                     decision, bestState);
            errorCount++;
          end
        end
      end
    end
  endtask

  // same pairing of I and Q strobes as the detector
  task automatic trackInputs();
    logic       modelBit;
    logic [1:0] modelState;
    if (sym2xEn && symEn) begin
      heldI = sampleIn;
      haveI = 1'b1;
    end else if (sym2xEn && haveI) begin
      haveI = 1'b0;
      modelStep(heldI, sampleIn, modelBit, modelState);
      if (modelSymbols > `TB_DEPTH) begin
        expBits.push_back(modelBit);
        expStates.push_back(modelState);
        qCycles.push_back(cycleCount);
      end
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      haveI = 1'b0;
      decisionsSinceReset = 0;
      modelClear();
      expBits.delete();
      expStates.delete();
      qCycles.delete();
    end else begin
      checkOutputs();
      trackInputs();
    end
  end

  // run limit
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount == CycleLimit) begin
      $display("timeout, the tests did not finish within %0d cycles", CycleLimit);
      $display("Something failed");
      $finish;
    end
  end

  // --------------------
  // test sequence
  // --------------------
  initial begin
    reset = 1'b1;
    symEn = 1'b0;
    sym2xEn = 1'b0;
    sampleIn = '0;

    startTest(ModeHistory);
    runStream(60, 20, 1'b0, 1'b0, 1'b0);
    finishTest(1, "noiseless random bits", 60 - `TB_DEPTH);

    startTest(ModeModel);
    runStream(80, 10, 1'b1, 1'b0, 1'b0);
    finishTest(2, "noisy random bits", 80 - `TB_DEPTH);

    startTest(ModeZero);
    runStream(40, SampleMax, 1'b0, 1'b1, 1'b0);
    finishTest(3, "all-zero full scale", 40 - `TB_DEPTH);

    startTest(ModeHistory);
    runStream(50, 20, 1'b0, 1'b0, 1'b1);
    finishTest(4, "irregular strobe spacing", 50 - `TB_DEPTH);

    // reset lands between the I and Q of a symbol
    startTest(ModeModel);
    runStream(30, 10, 1'b1, 1'b0, 1'b0);
    sendSample(1'b1, softValue(1'b0, 10, 1'b1), 0);
    applyReset();
    runStream(40, 10, 1'b1, 1'b0, 1'b0);
    finishTest(5, "reset in mid-stream", 40 - `TB_DEPTH);

    $display("5 tests, %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
